//--- design/ps2_pkg.sv
// shared types, prefix codes, register bit positions and defaults for the ps/2 port and its tests
package ps2_pkg;

    // one frame payload or one stored scancode
    typedef logic [7:0] ps2_byte_t;

    // keyboard prefix bytes
    // release of a key is announced by f0
    localparam ps2_byte_t break_prefix = 8'hf0;
    // extended keys carry an e0 in front of the code
    localparam ps2_byte_t extended_prefix = 8'he0;

    // position in the stored code that marks a key release
    localparam int release_bit = 7;

    // status byte layout, this byte is the high half of the read word
    localparam int stat_not_empty = 0;
    localparam int stat_unread_error = 1;
    localparam int stat_tx_busy = 2;

    // control bits in the write word, valid with bytesel[1]
    localparam int ctl_pop = 15;
    localparam int ctl_flush = 14;

    // defaults for the top level parameters
    localparam int default_clk_freq = 50_000_000;
    localparam int default_fifo_depth = 8;

endpackage

//--- design/ps2_rx.sv
// device-to-host frame receiver, fed with synchronized data and falling clock edges from ps2_line_if
`timescale 1ns/1ps

module ps2_rx (
    input  logic               clk,
    input  logic               reset,
    input  logic               line_dat,
    input  logic               clk_fall,
    output ps2_pkg::ps2_byte_t rx_byte,
    output logic               rx_valid,
    output logic               rx_error
);
    import ps2_pkg::*;

    // a frame stalled for 2 ms is abandoned
    localparam int watchdog_cycles = default_clk_freq / 500;
    localparam int wd_width = $clog2(watchdog_cycles + 1);

    // position in the 11-bit frame, 0 waits for the start bit
    logic [3:0]          bit_count;
    logic [wd_width-1:0] watchdog;
    logic                start_bad;
    logic                parity_acc;
    ps2_byte_t           shift_reg;
    logic                frame_done;

    // the stop bit is the 11th falling edge
    assign frame_done = clk_fall && (bit_count == 4'd10);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bit_count <= '0;
            watchdog <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= frame_done;
            if (clk_fall) begin
                watchdog <= '0;
                bit_count <= (bit_count == 4'd10) ? 4'd0 : bit_count + 4'd1;
            end else if (bit_count != 4'd0) begin
                // line clock stopped in the middle of a frame
                if (watchdog == wd_width'(watchdog_cycles)) begin
                    bit_count <= '0;
                    watchdog <= '0;
                end else begin
                    watchdog <= watchdog + 1'b1;
                end
            end
        end
    end

    // frame working bits, each frame starts them afresh at bit 0
    always_ff @(posedge clk) begin
        if (clk_fall) begin
            if (bit_count == 4'd0) begin
                // start bit must be low
                start_bad <= line_dat;
                parity_acc <= 1'b0;
            end else if (bit_count <= 4'd8) begin
                // data arrives lsb first
                shift_reg <= {line_dat, shift_reg[7:1]};
                parity_acc <= parity_acc ^ line_dat;
            end else if (bit_count == 4'd9) begin
                parity_acc <= parity_acc ^ line_dat;
            end else begin
                // odd parity over data and parity bit, stop bit must be high
                rx_byte <= shift_reg;
                rx_error <= start_bad | ~parity_acc | ~line_dat;
            end
        end
    end

endmodule

//--- design/ps2_tx.sv
// host-to-device frame transmitter, requests the bus and shifts one command byte on device clocks
`timescale 1ns/1ps

module ps2_tx #(
    parameter int clk_freq = ps2_pkg::default_clk_freq
) (
    input  logic               clk,
    input  logic               reset,
    input  ps2_pkg::ps2_byte_t tx_byte,
    input  logic               start_tx,
    input  logic               clk_fall,
    output logic               tx_busy,
    output logic               tx_complete,
    output logic               drive_clk_low,
    output logic               drive_dat_low
);

    // clock is held low for 100 us before the request
    localparam int inhibit_cycles = clk_freq / 10000;
    localparam int timer_width = $clog2(inhibit_cycles + 1);

    typedef enum logic [2:0] {
        st_idle,
        st_inhibit,
        st_request,
        st_shift,
        st_stop
    } tx_state_t;

    tx_state_t              state;
    logic [timer_width-1:0] timer;
    logic [3:0]             bit_count;
    logic                   dat_low;
    // parity in bit 8 above the byte, shifted out lsb first
    logic [8:0]             shift_reg;

    assign tx_busy = (state != st_idle);
    assign drive_clk_low = (state == st_inhibit);
    assign drive_dat_low = dat_low;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_idle;
            timer <= '0;
            bit_count <= '0;
            dat_low <= 1'b0;
            tx_complete <= 1'b0;
        end else begin
            tx_complete <= 1'b0;
            case (state)
                st_idle: begin
                    dat_low <= 1'b0;
                    timer <= '0;
                    if (start_tx) begin
                        state <= st_inhibit;
                    end
                end
                st_inhibit: begin
                    if (timer == timer_width'(inhibit_cycles - 1)) begin
                        // start bit, clock goes back to the device
                        dat_low <= 1'b1;
                        state <= st_request;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                st_request: begin
                    // first device clock takes data bit 0
                    if (clk_fall) begin
                        dat_low <= ~shift_reg[0];
                        bit_count <= 4'd1;
                        state <= st_shift;
                    end
                end
                st_shift: begin
                    if (clk_fall) begin
                        if (bit_count == 4'd9) begin
                            // data line released for the stop bit
                            dat_low <= 1'b0;
                            state <= st_stop;
                        end else begin
                            dat_low <= ~shift_reg[0];
                            bit_count <= bit_count + 4'd1;
                        end
                    end
                end
                st_stop: begin
                    // device acks at the edge that ends the stop bit
                    if (clk_fall) begin
                        tx_complete <= 1'b1;
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == st_idle) && start_tx) begin
            shift_reg <= {~^tx_byte, tx_byte};
        end else if (clk_fall && ((state == st_request) || (state == st_shift))) begin
            shift_reg <= {1'b0, shift_reg[8:1]};
        end
    end

endmodule

//--- design/ps2_line_if.sv
// open-drain line interface that shares the ps/2 clock and data lines between receiver and transmitter
`timescale 1ns/1ps

module ps2_line_if #(
    parameter int clk_freq = ps2_pkg::default_clk_freq
) (
    input  logic               clk,
    input  logic               reset,
    inout  wire                ps2_clk,
    inout  wire                ps2_dat,
    input  logic               start_tx,
    input  ps2_pkg::ps2_byte_t tx_byte,
    output logic               tx_busy,
    output ps2_pkg::ps2_byte_t rx_byte,
    output logic               rx_valid,
    output logic               rx_error
);

    logic [1:0] clk_sync;
    logic [1:0] dat_sync;
    logic       clk_prev;
    logic       clk_fall;
    logic       rx_clk_fall;
    logic       drive_clk_low;
    logic       drive_dat_low;

    // two-stage synchronizers, idle lines are high
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    assign clk_fall = clk_prev & ~clk_sync[1];
    // the receiver must not see the device clocking in a command
    assign rx_clk_fall = clk_fall & ~tx_busy;

    // lines are only ever pulled low, the pull-ups make the high level
    assign ps2_clk = drive_clk_low ? 1'b0 : 1'bz;
    assign ps2_dat = drive_dat_low ? 1'b0 : 1'bz;

    ps2_rx u_rx (
        .clk      (clk),
        .reset    (reset),
        .line_dat (dat_sync[1]),
        .clk_fall (rx_clk_fall),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .rx_error (rx_error)
    );

    ps2_tx #(
        .clk_freq (clk_freq)
    ) u_tx (
        .clk           (clk),
        .reset         (reset),
        .tx_byte       (tx_byte),
        .start_tx      (start_tx),
        .clk_fall      (clk_fall),
        .tx_busy       (tx_busy),
        .tx_complete   (),
        .drive_clk_low (drive_clk_low),
        .drive_dat_low (drive_dat_low)
    );

endmodule

//--- design/scancode_filter.sv
// keyboard prefix tracker, turns raw received bytes into one stored code per key event
`timescale 1ns/1ps

module scancode_filter (
    input  logic               clk,
    input  logic               reset,
    input  ps2_pkg::ps2_byte_t rx_byte,
    input  logic               rx_valid,
    input  logic               rx_error,
    output ps2_pkg::ps2_byte_t code,
    output logic               code_valid
);
    import ps2_pkg::*;

    // f0 seen, the next ordinary byte is a release
    logic release_pending;
    logic is_break;
    logic is_extended;
    logic is_ordinary;

    assign is_break = (rx_byte == break_prefix);
    assign is_extended = (rx_byte == extended_prefix);
    assign is_ordinary = rx_valid && !rx_error && !is_break && !is_extended;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            release_pending <= 1'b0;
            code_valid <= 1'b0;
        end else begin
            code_valid <= is_ordinary;
            if (rx_valid) begin
                if (rx_error) begin
                    // a broken frame loses the prefix context
                    release_pending <= 1'b0;
                end else if (is_break) begin
                    release_pending <= 1'b1;
                end else if (!is_extended) begin
                    release_pending <= 1'b0;
                end
            end
        end
    end

    // release is folded into the top bit of the code
    always_ff @(posedge clk) begin
        if (is_ordinary) begin
            code <= rx_byte;
            code[release_bit] <= rx_byte[release_bit] | release_pending;
        end
    end

endmodule

//--- design/sync_fifo.sv
// single-clock first-word-fall-through FIFO, the head word is always on rd_data
`timescale 1ns/1ps

module sync_fifo #(
    parameter int data_width = 8,
    parameter int depth = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  logic                  wr_en,
    input  logic [data_width-1:0] wr_data,
    input  logic                  rd_en,
    output logic [data_width-1:0] rd_data,
    output logic                  empty,
    output logic                  full
);

    localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_width = $clog2(depth + 1);

    logic [data_width-1:0]  mem [depth];
    logic [ptr_width-1:0]   wr_ptr;
    logic [ptr_width-1:0]   rd_ptr;
    logic [count_width-1:0] count;
    logic                   do_write;
    logic                   do_read;

    assign do_write = wr_en && !full;
    assign do_read = rd_en && !empty;
    assign empty = (count == '0);
    assign full = (count == count_width'(depth));
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            // pointers wrap at depth so any depth works
            if (do_write) begin
                wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_write && !do_read) begin
                count <= count + 1'b1;
            end else if (do_read && !do_write) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

//--- design/ps2_controller.sv
// memory-mapped ps/2 keyboard port, the top level seen by the processor bus
`timescale 1ns/1ps

module ps2_controller #(
    parameter int clk_freq = ps2_pkg::default_clk_freq,
    parameter int fifo_depth = ps2_pkg::default_fifo_depth
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        cs,
    input  logic        data_m_access,
    input  logic        data_m_wr_en,
    input  logic [1:0]  data_m_bytesel,
    input  logic [15:0] data_m_data_in,
    output logic [15:0] data_m_data_out,
    output logic        data_m_ack,
    output logic        ps2_intr,
    inout  wire         ps2_clk,
    inout  wire         ps2_dat
);
    import ps2_pkg::*;

    logic      do_read;
    logic      do_write;
    logic      start_tx;
    logic      tx_busy;
    ps2_byte_t rx_byte;
    logic      rx_valid;
    logic      rx_error;
    ps2_byte_t code;
    logic      code_valid;
    logic      fifo_push;
    logic      fifo_pop;
    logic      fifo_flush;
    ps2_byte_t fifo_head;
    logic      empty;
    logic      full;
    logic      unread_error;
    ps2_byte_t status;
    ps2_byte_t data_byte;

    // bus decode
    assign do_read = data_m_access && cs && !data_m_wr_en;
    assign do_write = data_m_access && cs && data_m_wr_en;
    // low byte write sends a command unless one is still going out
    assign start_tx = do_write && data_m_bytesel[0] && !tx_busy;
    assign fifo_flush = do_write && data_m_bytesel[1] && data_m_data_in[ctl_flush];
    assign fifo_pop = do_write && data_m_bytesel[1] && data_m_data_in[ctl_pop] && !empty;

    // zero codes are never stored, a full FIFO drops new codes
    assign fifo_push = code_valid && !full && (code != '0);
    assign ps2_intr = fifo_push;

    always_comb begin
        status = '0;
        status[stat_not_empty] = !empty;
        status[stat_unread_error] = unread_error;
        status[stat_tx_busy] = tx_busy;
    end

    assign data_byte = empty ? '0 : fifo_head;

    // read word and ack one cycle after the access, word is zero otherwise
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            data_m_ack <= 1'b0;
            data_m_data_out <= '0;
            unread_error <= 1'b0;
        end else begin
            data_m_ack <= data_m_access && cs;
            data_m_data_out <= do_read ? {status, data_byte} : 16'h0000;
            // a new error wins over the clearing read
            if (rx_valid && rx_error) begin
                unread_error <= 1'b1;
            end else if (do_read && data_m_bytesel[1]) begin
                unread_error <= 1'b0;
            end
        end
    end

    ps2_line_if #(
        .clk_freq (clk_freq)
    ) u_line_if (
        .clk      (clk),
        .reset    (reset),
        .ps2_clk  (ps2_clk),
        .ps2_dat  (ps2_dat),
        .start_tx (start_tx),
        .tx_byte  (data_m_data_in[7:0]),
        .tx_busy  (tx_busy),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .rx_error (rx_error)
    );

    scancode_filter u_filter (
        .clk        (clk),
        .reset      (reset),
        .rx_byte    (rx_byte),
        .rx_valid   (rx_valid),
        .rx_error   (rx_error),
        .code       (code),
        .code_valid (code_valid)
    );

    sync_fifo #(
        .data_width ($bits(ps2_byte_t)),
        .depth      (fifo_depth)
    ) u_fifo (
        .clk     (clk),
        .reset   (reset),
        .flush   (fifo_flush),
        .wr_en   (fifo_push),
        .wr_data (code),
        .rd_en   (fifo_pop),
        .rd_data (fifo_head),
        .empty   (empty),
        .full    (full)
    );

endmodule

//--- verif/ps2_device_model.sv
// behavioral ps/2 keyboard for the testbench, sends device frames and clocks in host commands
`timescale 1ns/1ps

module ps2_device_model #(
    parameter int half_cycles = 40
) (
    input logic clk,
    inout wire  ps2_clk,
    inout wire  ps2_dat
);

    // line pull-down requests, released means high through the pull-ups
    logic       clk_low = 1'b0;
    logic       dat_low = 1'b0;
    // last host frame as seen by the keyboard
    logic [7:0] host_byte = 8'h00;
    logic       host_parity_ok = 1'b0;
    logic       host_stop_ok = 1'b0;

    assign ps2_clk = clk_low ? 1'b0 : 1'bz;
    assign ps2_dat = dat_low ? 1'b0 : 1'bz;

    // one line clock period, high half first
    task automatic clock_pulse();
        repeat (half_cycles) @(posedge clk);
        clk_low <= 1'b1;
        repeat (half_cycles) @(posedge clk);
        clk_low <= 1'b0;
    endtask

    // device frame: start, data lsb first, odd parity, stop
    task automatic send_byte(input logic [7:0] value, input bit bad_parity);
        logic [10:0] frame;
        frame = {1'b1, (~^value) ^ bad_parity, value, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(posedge clk);
            dat_low <= ~frame[i];
            clock_pulse();
        end
    endtask

    // waits for the host request, then clocks in data, parity and stop
    task automatic receive_host_frame(input int timeout_cycles, output bit ok);
        logic [10:0] frame;
        int          waited;
        ok = 1'b0;
        waited = 0;
        frame = '0;
        // host inhibits first by holding the clock low
        while (ps2_clk != 1'b0 && waited < timeout_cycles) begin
            @(posedge clk);
            waited++;
        end
        // then releases the clock with the data line held low
        while (ps2_clk != 1'b1 && waited < timeout_cycles) begin
            @(posedge clk);
            waited++;
        end
        if (waited < timeout_cycles && ps2_dat == 1'b0) begin
            // host data is read once the clock is high again
            for (int i = 0; i < 11; i++) begin
                clock_pulse();
                @(posedge clk);
                frame[i] = ps2_dat;
            end
            host_byte = frame[7:0];
            host_parity_ok = ^frame[8:0];
            host_stop_ok = frame[9];
            ok = 1'b1;
        end
    endtask

endmodule

//--- verif/ps2_tb.sv
// testbench top for the ps/2 keyboard port that drives the bus and a keyboard model and checks the responses
`timescale 1ns/1ps

module ps2_tb;
    import ps2_pkg::*;

    localparam int clk_freq = 10_000_000;
    localparam int fifo_depth = 8;
    // keyboard line clock in system cycles per half period
    localparam int half_cycles = 40;
    localparam int ack_timeout = 8;
    localparam int event_timeout = 400;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        cs = 1'b0;
    logic        data_m_access = 1'b0;
    logic        data_m_wr_en = 1'b0;
    logic [1:0]  data_m_bytesel = 2'b00;
    logic [15:0] data_m_data_in = 16'h0000;
    wire  [15:0] data_m_data_out;
    wire         data_m_ack;
    wire         ps2_intr;
    wire         ps2_clk;
    wire         ps2_dat;
    int          intr_count = 0;
    logic [15:0] word;
    ps2_byte_t   sent[$];
    bit          ok;

    // idle level of both open-drain lines
    pullup (ps2_clk);
    pullup (ps2_dat);

    always #50 clk = ~clk;

    ps2_controller #(
        .clk_freq   (clk_freq),
        .fifo_depth (fifo_depth)
    ) u_dut (
        .clk             (clk),
        .reset           (reset),
        .cs              (cs),
        .data_m_access   (data_m_access),
        .data_m_wr_en    (data_m_wr_en),
        .data_m_bytesel  (data_m_bytesel),
        .data_m_data_in  (data_m_data_in),
        .data_m_data_out (data_m_data_out),
        .data_m_ack      (data_m_ack),
        .ps2_intr        (ps2_intr),
        .ps2_clk         (ps2_clk),
        .ps2_dat         (ps2_dat)
    );

    ps2_device_model #(
        .half_cycles (half_cycles)
    ) u_kbd (
        .clk     (clk),
        .ps2_clk (ps2_clk),
        .ps2_dat (ps2_dat)
    );

    // one count per stored code
    always @(posedge clk) begin
        if (ps2_intr) begin
            intr_count <= intr_count + 1;
        end
    end

    task automatic check_failed(input string what);
        $display("CHECK FAILED at %0t ns: %s", $time, what);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic timed_out(input string what);
        $display("timeout at %0t ns while waiting for %s", $time, what);
        $display("Regression failed");
        $fatal(1);
    endtask

    // bus protocol
    ack_follows_access: assert property (@(posedge clk) disable iff (reset)
        (data_m_access && cs) |=> data_m_ack)
        else check_failed("no ack one cycle after an access");
    ack_has_access: assert property (@(posedge clk) disable iff (reset)
        data_m_ack |-> $past(data_m_access && cs))
        else check_failed("ack without an access");
    out_zero_idle: assert property (@(posedge clk) disable iff (reset)
        !data_m_ack |-> (data_m_data_out == 16'h0000))
        else check_failed("read word not zero outside an ack cycle");
    intr_one_cycle: assert property (@(posedge clk) disable iff (reset)
        ps2_intr |=> !ps2_intr)
        else check_failed("interrupt longer than one cycle");

    // one bus access that returns the word of its ack cycle
    task automatic bus_access(input bit write, input logic [1:0] bytesel,
                              input logic [15:0] wdata, output logic [15:0] rdata);
        int waited;
        @(posedge clk);
        cs <= 1'b1;
        data_m_access <= 1'b1;
        data_m_wr_en <= write;
        data_m_bytesel <= bytesel;
        data_m_data_in <= wdata;
        @(posedge clk);
        cs <= 1'b0;
        data_m_access <= 1'b0;
        data_m_wr_en <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (!data_m_ack) begin
            if (waited == ack_timeout) timed_out("bus ack");
            @(negedge clk);
            waited++;
        end
        rdata = data_m_data_out;
    endtask

    // status read on both lanes also clears the error latch
    // no transmit is running here, so tx_busy and the spare status bits read as zero
    task automatic expect_read(input bit not_empty, input bit err, input ps2_byte_t data,
                               input string what);
        logic [15:0] expected;
        expected = {8'h00, data};
        expected[8 + stat_not_empty] = not_empty;
        expected[8 + stat_unread_error] = err;
        bus_access(1'b0, 2'b11, 16'h0000, word);
        assert (word == expected)
            else check_failed($sformatf("%s, read word %h, expected %h", what, word,
                                        expected));
    endtask

    task automatic write_ctl(input int bit_pos);
        bus_access(1'b1, 2'b10, 16'h0001 << bit_pos, word);
    endtask

    // prefixes and dropped codes leave the target at its old value
    task automatic send_and_wait(input ps2_byte_t value, input int target);
        int waited;
        u_kbd.send_byte(value, 1'b0);
        waited = 0;
        while (intr_count < target) begin
            if (waited == event_timeout) timed_out("key code interrupt");
            @(negedge clk);
            waited++;
        end
        repeat (4) @(negedge clk);
        assert (intr_count == target)
            else check_failed($sformatf("%0d interrupts, expected %0d", intr_count, target));
    endtask

    initial begin
        int base;
        int waited;
        void'($urandom(32'h4cf55f36));
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(posedge clk);

        // make code and then a pop
        send_and_wait(8'h1c, 1);
        expect_read(1'b1, 1'b0, 8'h1c, "make code");
        write_ctl(ctl_pop);
        expect_read(1'b0, 1'b0, 8'h00, "read after pop");

        // release folds into bit 7 and the extended prefix vanishes
        send_and_wait(break_prefix, 1);
        send_and_wait(8'h1c, 2);
        send_and_wait(extended_prefix, 2);
        send_and_wait(8'h75, 3);
        expect_read(1'b1, 1'b0, 8'h9c, "release code");
        write_ctl(ctl_pop);
        expect_read(1'b1, 1'b0, 8'h75, "extended code");
        write_ctl(ctl_pop);

        // bad parity stores nothing and sets the latch until read
        base = intr_count;
        u_kbd.send_byte(8'h1c, 1'b1);
        repeat (4) @(negedge clk);
        assert (intr_count == base) else check_failed("interrupt for a parity error");
        expect_read(1'b0, 1'b1, 8'h00, "parity error flagged");
        expect_read(1'b0, 1'b0, 8'h00, "error cleared by read");

        // one more code than the FIFO holds
        for (int i = 0; i < fifo_depth + 1; i++) begin
            sent.push_back(8'(1 + $urandom % 127));
            send_and_wait(sent[i], base + ((i < fifo_depth) ? i + 1 : fifo_depth));
        end
        for (int i = 0; i < fifo_depth; i++) begin
            expect_read(1'b1, 1'b0, sent[i], "code read back in order");
            write_ctl(ctl_pop);
        end
        expect_read(1'b0, 1'b0, 8'h00, "ninth code dropped");
        send_and_wait(8'h2a, base + fifo_depth + 1);
        send_and_wait(8'h33, base + fifo_depth + 2);
        write_ctl(ctl_flush);
        expect_read(1'b0, 1'b0, 8'h00, "flush empties the FIFO");

        // command byte to the keyboard
        base = intr_count;
        bus_access(1'b1, 2'b01, 16'h00ed, word);
        bus_access(1'b0, 2'b01, 16'h0000, word);
        assert (word[8 + stat_tx_busy]) else check_failed("tx_busy not set after a command");
        u_kbd.receive_host_frame(3 * clk_freq / 10000, ok);
        if (!ok) timed_out("host request to send");
        assert (u_kbd.host_byte == 8'hed && u_kbd.host_parity_ok && u_kbd.host_stop_ok)
            else check_failed($sformatf("host frame %h, parity ok %0b", u_kbd.host_byte,
                                        u_kbd.host_parity_ok));
        waited = 0;
        while (word[8 + stat_tx_busy]) begin
            if (waited == event_timeout) timed_out("end of transmit");
            bus_access(1'b0, 2'b01, 16'h0000, word);
            waited++;
        end
        assert (intr_count == base) else check_failed("code stored from a transmit");
        expect_read(1'b0, 1'b0, 8'h00, "FIFO empty after transmit");

        $display("Regression passed");
        $finish;
    end

endmodule

//--- tb.f
design/ps2_pkg.sv
design/ps2_rx.sv
design/ps2_tx.sv
design/ps2_line_if.sv
design/scancode_filter.sv
design/sync_fifo.sv
design/ps2_controller.sv
verif/ps2_device_model.sv
verif/ps2_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = ps2_tb
FILELIST = tb.f
OBJ_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Regression passed"

clean:
	rm -rf $(OBJ_DIR)
